// ==== common/dcache_pkg.sv ====
// Data cache shared definitions

package dcache_pkg;

  // ============================================================
  // Cache geometry
  // ============================================================

  // Physical address width of the load path
  localparam int AWID = 32;

  // Four ways of 128 sets each
  localparam int NWAYS = 4;
  localparam int NSETS = 128;

  // 64-byte lines, so six offset bits and seven index bits
  localparam int OFFS_BITS = 6;
  localparam int NDX_BITS = 7;

  // Width of a way number
  localparam int WAY_BITS = 2;

  // A line holds sixteen 32-bit words
  localparam int WORD_BITS = 32;
  localparam int LINE_WORDS = 16;

  // ============================================================
  // Basic types
  // ============================================================

  typedef logic [AWID-1:0] phys_addr_t;

  // The tag is every address bit above the line offset and so includes the index
  typedef logic [AWID-OFFS_BITS-1:0] tag_t;
  typedef logic [NDX_BITS-1:0] ndx_t;
  typedef logic [WAY_BITS-1:0] way_t;
  typedef logic [WORD_BITS-1:0] word_t;

  // Word k of a line sits at index k
  typedef word_t [LINE_WORDS-1:0] line_t;

  // Everything one set holds, indexed by way
  typedef tag_t [NWAYS-1:0] tag_set_t;
  typedef line_t [NWAYS-1:0] line_set_t;

  // One valid bit per set for a single way
  typedef logic [NSETS-1:0] valid_vec_t;

  // ============================================================
  // Structs exchanged between blocks
  // ============================================================

  typedef struct packed {
    phys_addr_t adr;
  } cpu_req_t;

  typedef struct packed {
    word_t data;
  } cpu_rsp_t;

  // One refill write, shared by the way RAMs, valid store and victim selector
  typedef struct packed {
    way_t way;
    ndx_t ndx;
    tag_t tag;
    line_t line;
  } fill_t;

endpackage

// ==== dcache/dcache_hit.sv ====
// Four-way hit detector

`timescale 1ns/1ps

module dcache_hit (
  input  logic                                              clk,
  input  logic                                              rst,
  input  dcache_pkg::tag_set_t                              tags,
  input  dcache_pkg::ndx_t                                  ndx,
  input  dcache_pkg::phys_addr_t                            adr,
  input  dcache_pkg::valid_vec_t [dcache_pkg::NWAYS-1:0]    valid,
  output logic [dcache_pkg::NWAYS-1:0]                      hits,
  output logic                                              hit,
  output dcache_pkg::way_t                                  rway
);

  // A way hits when its stored tag matches and its valid bit for this set is up
  always_comb
  begin
    for (int w = 0; w < dcache_pkg::NWAYS; w++)
    begin
      hits[w] = (tags[w] == adr[dcache_pkg::AWID-1:dcache_pkg::OFFS_BITS]) && valid[w][ndx];
    end
  end

  // Register the hit flag and the lowest way that hit
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hit  <= 1'b0;
      rway <= '0;
    end
    else
    begin
      hit <= |hits;
      // With no hit the previous way stays on rway
      // Walk downwards so the lowest hitting way is the one that sticks
      for (int w = dcache_pkg::NWAYS - 1; w >= 0; w--)
      begin
        if (hits[w])
          rway <= dcache_pkg::way_t'(w);
      end
    end
  end

endmodule

// ==== dcache/dcache_way_ram.sv ====
// Set-organized way RAM

`timescale 1ns/1ps

module dcache_way_ram #(
  parameter type entry_t = dcache_pkg::tag_t
) (
  input  logic                              clk,
  input  logic                              rd_en,
  input  dcache_pkg::ndx_t                  rd_ndx,
  output entry_t [dcache_pkg::NWAYS-1:0]    rd_data,
  input  logic                              wr_en,
  input  dcache_pkg::ndx_t                  wr_ndx,
  input  dcache_pkg::way_t                  wr_way,
  input  entry_t                            wr_data
);

  // ============================================================
  // Storage
  // ============================================================

  // One row per set, each row carrying an entry for every way
  entry_t [dcache_pkg::NWAYS-1:0] mem [dcache_pkg::NSETS];

  // ============================================================
  // Read and write ports
  // ============================================================

  // Synchronous read of a whole row
  // The output register keeps its value until the next read
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_ndx];
  end

  // A write replaces a single way of one row
  // The other ways of the row are left as they are
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ndx][wr_way] <= wr_data;
  end

endmodule

// ==== dcache/dcache_valid.sv ====
// Valid-bit store

`timescale 1ns/1ps

module dcache_valid (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              inv,
  input  logic                                              fill_en,
  input  dcache_pkg::fill_t                                 fill,
  output dcache_pkg::valid_vec_t [dcache_pkg::NWAYS-1:0]    valid
);

  // ============================================================
  // Valid flip-flops
  // ============================================================

  // One bit per way and set, all held in flops so a global clear takes one cycle
  // Invalidate wins over a fill arriving in the same cycle
  always_ff @(posedge clk)
  begin
    if (rst || inv)
    begin
      valid <= '0;
    end
    else if (fill_en)
    begin
      // The refilled way of the refilled set becomes usable
      valid[fill.way][fill.ndx] <= 1'b1;
    end
  end

  // Bits are never cleared one at a time since the cache holds no dirty data
  // and a refill only ever overwrites a way, so the only way down is a full clear

endmodule

// ==== dcache/dcache_victim.sv ====
// Refill victim selector

`timescale 1ns/1ps

module dcache_victim (
  input  logic                                              clk,
  input  logic                                              rst,
  input  dcache_pkg::ndx_t                                  ndx,
  input  dcache_pkg::valid_vec_t [dcache_pkg::NWAYS-1:0]    valid,
  input  logic                                              fill_en,
  input  dcache_pkg::fill_t                                 fill,
  output dcache_pkg::way_t                                  victim
);

  // Round-robin pointer of every set
  dcache_pkg::way_t [dcache_pkg::NSETS-1:0] rr;

  // Set when every way of the set being filled already holds a line
  logic fill_set_full;

  // Pick the lowest invalid way of the current set, else the round-robin way
  always_comb
  begin
    victim = rr[ndx];
    for (int w = dcache_pkg::NWAYS - 1; w >= 0; w--)
    begin
      if (!valid[w][ndx])
        victim = dcache_pkg::way_t'(w);
    end
  end

  // Look at the set named by the fill rather than the lookup index
  always_comb
  begin
    fill_set_full = 1'b1;
    for (int w = 0; w < dcache_pkg::NWAYS; w++)
    begin
      if (!valid[w][fill.ndx])
        fill_set_full = 1'b0;
    end
  end

  // ============================================================
  // Round-robin counters
  // ============================================================

  // A pointer only moves when a full set loses a line, so it always
  // points at the way that was replaced longest ago
  always_ff @(posedge clk)
  begin
    if (rst)
      rr <= '0;
    else if (fill_en && fill_set_full)
      rr[fill.ndx] <= rr[fill.ndx] + 1'b1;
  end

endmodule

// ==== dcache/dcache_ctrl.sv ====
// Data cache controller

`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  dcache_pkg::cpu_req_t    req_info,
  output logic                    busy,
  output logic                    rsp_valid,
  output dcache_pkg::cpu_rsp_t    rsp_info,
  output logic                    lookup_en,
  output dcache_pkg::ndx_t        ndx,
  output dcache_pkg::phys_addr_t  adr,
  input  logic                    hit,
  input  dcache_pkg::way_t        rway,
  input  dcache_pkg::line_set_t   lines,
  input  dcache_pkg::way_t        victim,
  output logic                    fill_en,
  output dcache_pkg::fill_t       fill,
  output logic                    mem_req,
  output dcache_pkg::tag_t        mem_adr,
  input  logic                    mem_ack,
  input  dcache_pkg::line_t       mem_line
);

  typedef enum logic [2:0] {
    IDLE,
    READ,
    COMPARE,
    MISS,
    FILL,
    REPLAY
  } state_t;

  state_t state;
  state_t state_nxt;

  // Address of the load in flight
  dcache_pkg::phys_addr_t adr_q;

  // Line returned by memory, held for the fill cycle
  dcache_pkg::line_t line_q;

  // ============================================================
  // Lookup address
  // ============================================================

  // While idle the request address goes straight to the RAMs so the read
  // starts on the accepting edge, otherwise the held address is used
  assign adr = (state == IDLE) ? req_info.adr : adr_q;
  assign ndx = adr[dcache_pkg::OFFS_BITS +: dcache_pkg::NDX_BITS];

  // The RAMs are read on acceptance and again on a replay
  assign lookup_en = ((state == IDLE) && req) || (state == REPLAY);

  // ============================================================
  // State machine
  // ============================================================

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      IDLE:    if (req) state_nxt = READ;
      // RAM data is settling, the hit detector samples at the end of this cycle
      READ:    state_nxt = COMPARE;
      COMPARE: state_nxt = hit ? IDLE : MISS;
      MISS:    if (mem_ack) state_nxt = FILL;
      FILL:    state_nxt = REPLAY;
      REPLAY:  state_nxt = READ;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Capture the load address on acceptance
  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && req)
      adr_q <= req_info.adr;
  end

  // Capture the returned line on the acknowledge cycle
  always_ff @(posedge clk)
  begin
    if ((state == MISS) && mem_ack)
      line_q <= mem_line;
  end

  // ============================================================
  // Outputs
  // ============================================================

  assign busy = (state != IDLE);

  // The hit flag registered in READ is valid throughout COMPARE
  assign rsp_valid = (state == COMPARE) && hit;

  // Address bits 5 down to 2 pick the word out of the hitting way's line
  assign rsp_info.data = lines[rway][adr_q[dcache_pkg::OFFS_BITS-1:2]];

  // Memory request is held from the miss until the acknowledge
  assign mem_req = (state == MISS);
  assign mem_adr = adr_q[dcache_pkg::AWID-1:dcache_pkg::OFFS_BITS];

  // Refill write goes to the way chosen by the victim selector
  assign fill_en   = (state == FILL);
  assign fill.way  = victim;
  assign fill.ndx  = adr_q[dcache_pkg::OFFS_BITS +: dcache_pkg::NDX_BITS];
  assign fill.tag  = mem_adr;
  assign fill.line = line_q;

endmodule

// ==== src/dcache_top.sv ====
// Data cache top level

`timescale 1ns/1ps

module dcache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req,
  input  dcache_pkg::cpu_req_t    req_info,
  output logic                    busy,
  output logic                    rsp_valid,
  output dcache_pkg::cpu_rsp_t    rsp_info,
  input  logic                    inv,
  output logic                    mem_req,
  output dcache_pkg::tag_t        mem_adr,
  input  logic                    mem_ack,
  input  dcache_pkg::line_t       mem_line
);

  // ============================================================
  // Internal wiring
  // ============================================================

  logic                                             lookup_en;
  dcache_pkg::ndx_t                                 ndx;
  dcache_pkg::phys_addr_t                           adr;
  logic                                             hit;
  dcache_pkg::way_t                                 rway;
  dcache_pkg::way_t                                 victim;
  dcache_pkg::tag_set_t                             tags;
  dcache_pkg::line_set_t                            lines;
  dcache_pkg::valid_vec_t [dcache_pkg::NWAYS-1:0]   valid;
  logic                                             fill_en;
  dcache_pkg::fill_t                                fill;

  dcache_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_info  (req_info),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp_info  (rsp_info),
    .lookup_en (lookup_en),
    .ndx       (ndx),
    .adr       (adr),
    .hit       (hit),
    .rway      (rway),
    .lines     (lines),
    .victim    (victim),
    .fill_en   (fill_en),
    .fill      (fill),
    .mem_req   (mem_req),
    .mem_adr   (mem_adr),
    .mem_ack   (mem_ack),
    .mem_line  (mem_line)
  );

  // Tags and line data share the RAM module, one instance per payload
  dcache_way_ram #(.entry_t(dcache_pkg::tag_t)) u_tag_ram (
    .clk     (clk),
    .rd_en   (lookup_en),
    .rd_ndx  (ndx),
    .rd_data (tags),
    .wr_en   (fill_en),
    .wr_ndx  (fill.ndx),
    .wr_way  (fill.way),
    .wr_data (fill.tag)
  );

  dcache_way_ram #(.entry_t(dcache_pkg::line_t)) u_data_ram (
    .clk     (clk),
    .rd_en   (lookup_en),
    .rd_ndx  (ndx),
    .rd_data (lines),
    .wr_en   (fill_en),
    .wr_ndx  (fill.ndx),
    .wr_way  (fill.way),
    .wr_data (fill.line)
  );

  dcache_valid u_valid (
    .clk     (clk),
    .rst     (rst),
    .inv     (inv),
    .fill_en (fill_en),
    .fill    (fill),
    .valid   (valid)
  );

  // Per-way hit vector is only needed inside the detector
  dcache_hit u_hit (
    .clk   (clk),
    .rst   (rst),
    .tags  (tags),
    .ndx   (ndx),
    .adr   (adr),
    .valid (valid),
    .hits  (),
    .hit   (hit),
    .rway  (rway)
  );

  dcache_victim u_victim (
    .clk     (clk),
    .rst     (rst),
    .ndx     (ndx),
    .valid   (valid),
    .fill_en (fill_en),
    .fill    (fill),
    .victim  (victim)
  );

endmodule

// ==== dv/tb_dcache.sv ====
// Data cache directed testbench

`timescale 1ns/1ps

module tb_dcache;

  // ============================================================
  // Timing and address constants
  // ============================================================

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 16;
  // Longest load is three lookup cycles, eight memory cycles, refill, replay and margin
  localparam int WORST_LOAD_CYCLES = 33;
  localparam int MAX_LOADS = 60;
  localparam int WATCHDOG_NS = (RESET_CYCLES + MAX_LOADS * WORST_LOAD_CYCLES) * CLK_PERIOD;
  // A single load that runs past this many cycles has lost its response
  localparam int LOAD_LIMIT = 40;

  localparam dcache_pkg::phys_addr_t ADR_COLD = 32'h0001_2344;
  localparam dcache_pkg::phys_addr_t LINE_BASE = 32'h0004_5680;
  localparam dcache_pkg::phys_addr_t BUSY_ADR = 32'h0009_1238;
  localparam dcache_pkg::phys_addr_t STRAY_ADR = 32'h000a_4564;
  // Set shared by the way filling and replacement tests
  localparam dcache_pkg::ndx_t SET_NDX = 7'h33;

  logic                   clk;
  logic                   rst;
  logic                   req;
  dcache_pkg::cpu_req_t   req_info;
  logic                   busy;
  logic                   rsp_valid;
  dcache_pkg::cpu_rsp_t   rsp_info;
  logic                   inv;
  logic                   mem_req;
  dcache_pkg::tag_t       mem_adr;
  logic                   mem_ack;
  dcache_pkg::line_t      mem_line;

  int check_errors = 0;
  int other_errors = 0;
  int mem_req_count = 0;
  int rsp_count = 0;
  int seed = 32'he0db_8fca;
  logic mem_req_prev;
  dcache_pkg::tag_t last_mem_adr;

  dcache_top u_dcache_top (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_info  (req_info),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp_info  (rsp_info),
    .inv       (inv),
    .mem_req   (mem_req),
    .mem_adr   (mem_adr),
    .mem_ack   (mem_ack),
    .mem_line  (mem_line)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ============================================================
  // Memory model and expected data
  // ============================================================

  // Word k of the line at tag t is t times 16 plus k
  function automatic dcache_pkg::word_t model_word(input dcache_pkg::tag_t tag, input int k);
    return dcache_pkg::word_t'(tag) * 32'd16 + dcache_pkg::word_t'(k);
  endfunction

  function automatic dcache_pkg::line_t make_line(input dcache_pkg::tag_t tag);
    dcache_pkg::line_t line;
    for (int k = 0; k < dcache_pkg::LINE_WORDS; k++)
      line[k] = model_word(tag, k);
    return line;
  endfunction

  // A load returns the word picked by address bits 5 down to 2
  function automatic dcache_pkg::word_t expected_word(input dcache_pkg::phys_addr_t adr);
    return model_word(adr[31:6], int'(adr[5:2]));
  endfunction

  // Line i of the shared set, tags differing above the index bits
  function automatic dcache_pkg::phys_addr_t set_line_adr(input int i);
    return dcache_pkg::phys_addr_t'((i + 1) << 13) | {19'b0, SET_NDX, 6'h08};
  endfunction

  // Answers each memory request after 1 to 8 cycles with a one-cycle acknowledge
  initial
  begin : memory_model
    int delay;
    dcache_pkg::tag_t tag;
    forever
    begin
      @(negedge clk);
      if (mem_req && !mem_ack)
      begin
        tag = mem_adr;
        last_mem_adr = tag;
        delay = 1 + ({$random(seed)} % 8);
        repeat (delay) @(posedge clk);
        mem_ack <= 1'b1;
        mem_line <= make_line(tag);
        @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  // Count memory request rising edges and responses where both are stable
  always @(negedge clk)
  begin
    if (rst)
    begin
      mem_req_prev <= 1'b0;
    end
    else
    begin
      if (mem_req && !mem_req_prev)
        mem_req_count++;
      if (rsp_valid)
        rsp_count++;
      mem_req_prev <= mem_req;
    end
  end

  // ============================================================
  // Helper tasks
  // ============================================================

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      check_errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy)
      @(negedge clk);
  endtask

  // One-cycle request strobe, dropped on the following edge
  task automatic issue_req(input dcache_pkg::phys_addr_t adr);
    @(posedge clk);
    req <= 1'b1;
    req_info.adr <= adr;
    @(posedge clk);
    req <= 1'b0;
  endtask

  // Cycles are counted from the request cycle, which is cycle 0
  task automatic wait_rsp(output dcache_pkg::word_t data, output int cycles, output bit got);
    got = 1'b0;
    cycles = 1;
    data = '0;
    while (!got && cycles <= LOAD_LIMIT)
    begin
      @(negedge clk);
      if (rsp_valid)
      begin
        got = 1'b1;
        data = rsp_info.data;
      end
      else
        cycles++;
    end
  endtask

  // Issue a load and check its data, its miss count and, for a hit, its latency
  task automatic load(input string name, input dcache_pkg::phys_addr_t adr,
                      input bit expect_miss);
    int misses_before;
    int cycles;
    bit got;
    dcache_pkg::word_t data;
    wait_idle();
    misses_before = mem_req_count;
    issue_req(adr);
    wait_rsp(data, cycles, got);
    if (!got)
    begin
      other_errors++;
      $display("%s: no response to the load of %h within %0d cycles", name, adr, LOAD_LIMIT);
    end
    else
    begin
      check({name, " data"}, expected_word(adr), data);
      check({name, " misses"}, expect_miss ? 1 : 0, mem_req_count - misses_before);
      if (!expect_miss)
        check({name, " latency"}, 2, cycles);
    end
  endtask

  // ============================================================
  // Tests
  // ============================================================

  task automatic cold_miss_hit();
    load("cold miss", ADR_COLD, 1'b1);
    check("cold miss mem_adr", ADR_COLD[31:6], last_mem_adr);
    load("warm hit", ADR_COLD, 1'b0);
  endtask

  // Only the first word of the line should go out to memory
  task automatic word_select();
    for (int k = 0; k < dcache_pkg::LINE_WORDS; k++)
      load($sformatf("word %0d", k), LINE_BASE + 4 * k, k == 0);
  endtask

  task automatic way_fill();
    for (int i = 0; i < dcache_pkg::NWAYS; i++)
      load($sformatf("fill line %0d", i), set_line_adr(i), 1'b1);
    for (int i = 0; i < dcache_pkg::NWAYS; i++)
      load($sformatf("filled line %0d", i), set_line_adr(i), 1'b0);
  endtask

  // Full set, counter at 0, so line 4 lands in way 0 and line 0 then in way 1
  task automatic round_robin();
    load("rr line 4", set_line_adr(4), 1'b1);
    load("rr line 0 again", set_line_adr(0), 1'b1);
    load("rr line 2 kept", set_line_adr(2), 1'b0);
    load("rr line 3 kept", set_line_adr(3), 1'b0);
    load("rr line 4 kept", set_line_adr(4), 1'b0);
    load("rr line 1 evicted", set_line_adr(1), 1'b1);
  endtask

  task automatic invalidate_all();
    wait_idle();
    @(posedge clk);
    inv <= 1'b1;
    @(posedge clk);
    inv <= 1'b0;
    load("inv cold line", ADR_COLD, 1'b1);
    load("inv word line", LINE_BASE + 8, 1'b1);
    load("inv set line 3", set_line_adr(3), 1'b1);
    load("inv set line 4", set_line_adr(4), 1'b1);
    load("inv refetched", set_line_adr(3), 1'b0);
  endtask

  // A second strobe during a miss must neither answer nor fetch
  task automatic busy_ignore();
    int misses_before;
    int rsps_before;
    int cycles;
    bit got;
    dcache_pkg::word_t data;
    wait_idle();
    misses_before = mem_req_count;
    rsps_before = rsp_count;
    issue_req(BUSY_ADR);
    @(posedge clk);
    req <= 1'b1;
    req_info.adr <= STRAY_ADR;
    @(negedge clk);
    check("busy level", 1, busy);
    @(posedge clk);
    req <= 1'b0;
    wait_rsp(data, cycles, got);
    if (!got)
    begin
      other_errors++;
      $display("busy: the load under test never answered");
    end
    else
      check("busy data", expected_word(BUSY_ADR), data);
    repeat (20) @(negedge clk);
    check("busy responses", 1, rsp_count - rsps_before);
    check("busy misses", 1, mem_req_count - misses_before);
    // The stray address was never fetched, so it still misses
    load("stray line", STRAY_ADR, 1'b1);
  endtask

  // ============================================================
  // Sequence and watchdog
  // ============================================================

  initial
  begin
    rst = 1'b1;
    req = 1'b0;
    req_info = '0;
    inv = 1'b0;
    mem_ack = 1'b0;
    mem_line = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("reset busy", 0, busy);
    check("reset rsp_valid", 0, rsp_valid);
    check("reset mem_req", 0, mem_req);
    cold_miss_hit();
    word_select();
    way_fill();
    round_robin();
    invalidate_all();
    busy_ignore();
    $display("check errors %0d, other errors %0d", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("check errors %0d, other errors %0d", check_errors, other_errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
common/dcache_pkg.sv
dcache/dcache_hit.sv
dcache/dcache_way_ram.sv
dcache/dcache_valid.sv
dcache/dcache_victim.sv
dcache/dcache_ctrl.sv
src/dcache_top.sv
dv/tb_dcache.sv
